// File: Bender.yml
package:
  name: apu

sources:
  - files:
      - src/apu_reg_pkg.sv
      - src/apu_chan_pkg.sv
      - src/apu_ctrl.sv
      - src/apu_pulse_chan.sv
      - src/apu_mixer.sv
      - src/apu_top.sv
  - target: test
    files:
      - verif/apu_sva.sv
      - verif/apu_tb.sv

// File: compile.f
src/apu_reg_pkg.sv
src/apu_chan_pkg.sv
src/apu_ctrl.sv
src/apu_pulse_chan.sv
src/apu_mixer.sv
src/apu_top.sv
verif/apu_sva.sv
verif/apu_tb.sv

// File: src/apu_chan_pkg.sv
`default_nettype none

package apu_chan_pkg;

  typedef logic [3:0]  vol_t;
  typedef logic [10:0] freq_t;
  typedef logic [6:0]  len_t;
  typedef logic [2:0]  env_period_t;
  typedef logic [1:0]  duty_t;

  localparam int FRAME_W = 14;
  localparam int OUT_W   = 9;

  // ----------------------------------------
  // Frame sequencer tick patterns

  // Length tick when the low 12 bits are clear
  localparam logic [FRAME_W-1:0] LEN_TICK_MASK = 14'h0FFF;
  localparam logic [FRAME_W-1:0] ENV_TICK_VAL  = 14'h3800;

  // High steps out of eight for each duty code
  function automatic logic [2:0] duty_steps(input duty_t code);
    case (code)
      2'd0:    duty_steps = 3'd1;
      2'd1:    duty_steps = 3'd2;
      2'd2:    duty_steps = 3'd4;
      default: duty_steps = 3'd6;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: src/apu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module apu_ctrl #(
  parameter int N_CHAN = 2
) (
  input  logic                                    clk,
  input  logic                                    rst,
  input  apu_reg_pkg::addr_t                      addr,
  input  apu_reg_pkg::byte_t                      data,
  input  logic                                    read,
  input  logic                                    write,
  input  logic [N_CHAN-1:0]                       enabled,
  output apu_reg_pkg::byte_t                      bus_out,
  output logic                                    bus_oe,
  output logic [N_CHAN-1:0]                       trigger,
  output logic [N_CHAN-1:0]                       len_wr,
  output logic [N_CHAN-1:0][5:0]                  len_field,
  output logic [N_CHAN-1:0]                       len_en,
  output logic [N_CHAN-1:0]                       env_wr,
  output apu_chan_pkg::vol_t [N_CHAN-1:0]         env_init,
  output logic [N_CHAN-1:0]                       env_dir,
  output apu_chan_pkg::env_period_t [N_CHAN-1:0]  env_period,
  output apu_chan_pkg::freq_t [N_CHAN-1:0]        freq,
  output apu_chan_pkg::duty_t [N_CHAN-1:0]        duty,
  output logic                                    length_tick,
  output logic                                    env_tick,
  output logic                                    sound_on,
  output apu_reg_pkg::byte_t                      pan,
  output logic [2:0]                              master_l,
  output logic [2:0]                              master_r
);

  localparam int CIDX_W = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;

  typedef logic [CIDX_W-1:0] cidx_t;

  apu_reg_pkg::reg_sel_e             sel;
  cidx_t                             chan_idx;
  apu_reg_pkg::byte_t [N_CHAN-1:0]   len_duty_reg;
  apu_reg_pkg::byte_t [N_CHAN-1:0]   env_reg;
  apu_reg_pkg::byte_t [N_CHAN-1:0]   freq_lo_reg;
  apu_reg_pkg::byte_t [N_CHAN-1:0]   freq_hi_reg;
  apu_reg_pkg::byte_t                master_reg;
  apu_reg_pkg::byte_t                rd_data;
  logic [apu_chan_pkg::FRAME_W-1:0]  frame;

  // ----------------------------------------
  // Address decode

  always_comb begin
    sel      = apu_reg_pkg::REG_NONE;
    chan_idx = '0;
    for (int c = 0; c < N_CHAN; c++) begin
      for (int k = 0; k < 4; k++) begin
        if (addr == apu_reg_pkg::addr_t'(apu_reg_pkg::CHAN_BASE +
                                          c * apu_reg_pkg::CHAN_STRIDE + k)) begin
          sel      = apu_reg_pkg::reg_sel_e'(k);
          chan_idx = cidx_t'(c);
        end
      end
    end
    if (addr == apu_reg_pkg::ADDR_MASTER_VOL) sel = apu_reg_pkg::REG_MASTER_VOL;
    if (addr == apu_reg_pkg::ADDR_PAN)        sel = apu_reg_pkg::REG_PAN;
    if (addr == apu_reg_pkg::ADDR_POWER)      sel = apu_reg_pkg::REG_POWER;
  end

  // ----------------------------------------
  // Register storage

  always_ff @(posedge clk) begin
    if (rst) begin
      len_duty_reg <= '0;
      env_reg      <= '0;
      freq_lo_reg  <= '0;
      freq_hi_reg  <= '0;
      master_reg   <= '0;
      pan          <= '0;
      sound_on     <= 1'b0;
    end else if (write) begin
      case (sel)
        apu_reg_pkg::REG_LEN_DUTY:   len_duty_reg[chan_idx] <= data;
        apu_reg_pkg::REG_ENV:        env_reg[chan_idx]      <= data;
        apu_reg_pkg::REG_FREQ_LO:    freq_lo_reg[chan_idx]  <= data;
        apu_reg_pkg::REG_FREQ_HI:    freq_hi_reg[chan_idx]  <= data;
        apu_reg_pkg::REG_MASTER_VOL: master_reg             <= data;
        apu_reg_pkg::REG_PAN:        pan                    <= data;
        apu_reg_pkg::REG_POWER:      sound_on               <= data[7];
        default: ;
      endcase
    end
  end

  assign master_l = master_reg[6:4];
  assign master_r = master_reg[2:0];

  // Fields follow the bus byte during its write cycle
  for (genvar c = 0; c < N_CHAN; c++) begin : g_chan
    logic               hit;
    apu_reg_pkg::byte_t len_duty_now;
    apu_reg_pkg::byte_t env_now;
    apu_reg_pkg::byte_t freq_lo_now;
    apu_reg_pkg::byte_t freq_hi_now;

    assign hit = write && (chan_idx == cidx_t'(c));

    assign len_duty_now = (hit && sel == apu_reg_pkg::REG_LEN_DUTY) ? data : len_duty_reg[c];
    assign env_now      = (hit && sel == apu_reg_pkg::REG_ENV) ? data : env_reg[c];
    assign freq_lo_now  = (hit && sel == apu_reg_pkg::REG_FREQ_LO) ? data : freq_lo_reg[c];
    assign freq_hi_now  = (hit && sel == apu_reg_pkg::REG_FREQ_HI) ? data : freq_hi_reg[c];

    assign trigger[c]    = hit && (sel == apu_reg_pkg::REG_FREQ_HI) && data[7];
    assign len_wr[c]     = hit && (sel == apu_reg_pkg::REG_LEN_DUTY);
    assign len_field[c]  = data[5:0];
    assign len_en[c]     = freq_hi_now[6];
    assign env_wr[c]     = hit && (sel == apu_reg_pkg::REG_ENV);
    assign env_init[c]   = env_now[7:4];
    assign env_dir[c]    = env_now[3];
    assign env_period[c] = env_now[2:0];
    assign freq[c]       = {freq_hi_now[2:0], freq_lo_now};
    assign duty[c]       = len_duty_now[7:6];
  end

  // ----------------------------------------
  // Readback

  always_comb begin
    case (sel)
      apu_reg_pkg::REG_LEN_DUTY:
        rd_data = len_duty_reg[chan_idx] | apu_reg_pkg::MASK_LEN_DUTY;
      apu_reg_pkg::REG_ENV:        rd_data = env_reg[chan_idx] | apu_reg_pkg::MASK_ENV;
      apu_reg_pkg::REG_FREQ_LO:    rd_data = freq_lo_reg[chan_idx] | apu_reg_pkg::MASK_FREQ_LO;
      apu_reg_pkg::REG_FREQ_HI:    rd_data = freq_hi_reg[chan_idx] | apu_reg_pkg::MASK_FREQ_HI;
      apu_reg_pkg::REG_MASTER_VOL: rd_data = master_reg;
      apu_reg_pkg::REG_PAN:        rd_data = pan;
      apu_reg_pkg::REG_POWER:
        rd_data = {sound_on, 7'b0} | apu_reg_pkg::MASK_POWER_FILL |
                  apu_reg_pkg::byte_t'(enabled);
      default:                     rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bus_out <= '0;
      bus_oe  <= 1'b0;
    end else begin
      bus_oe  <= read && (sel != apu_reg_pkg::REG_NONE);
      bus_out <= read ? rd_data : '0;
    end
  end

  // ----------------------------------------
  // Frame sequencer

  always_ff @(posedge clk) begin
    if (rst) frame <= '0;
    else     frame <= frame + 1'b1;
  end

  assign length_tick = (frame & apu_chan_pkg::LEN_TICK_MASK) == '0;
  assign env_tick    = frame == apu_chan_pkg::ENV_TICK_VAL;

endmodule

`default_nettype wire

// File: src/apu_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module apu_mixer #(
  parameter int N_CHAN = 2
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  apu_chan_pkg::vol_t [N_CHAN-1:0]      sample,
  input  logic                                 sound_on,
  input  logic [7:0]                           pan,
  input  logic [2:0]                           master_l,
  input  logic [2:0]                           master_r,
  output logic [apu_chan_pkg::OUT_W-1:0]       out_l,
  output logic [apu_chan_pkg::OUT_W-1:0]       out_r
);

  typedef logic [apu_chan_pkg::OUT_W-1:0] mix_t;

  mix_t       sum_l;
  mix_t       sum_r;
  mix_t       mix_l;
  mix_t       mix_r;
  logic [3:0] gain_l;
  logic [3:0] gain_r;

  // Right side on pan bits 0-3, left side on bits 4-7
  always_comb begin
    sum_l = '0;
    sum_r = '0;
    for (int i = 0; i < N_CHAN; i++) begin
      if (pan[i]) sum_r = sum_r + mix_t'(sample[i]);
      if (pan[i + 4]) sum_l = sum_l + mix_t'(sample[i]);
    end
  end

  // Master volume 0-7 scales by 1-8
  assign gain_l = {1'b0, master_l} + 4'd1;
  assign gain_r = {1'b0, master_r} + 4'd1;
  assign mix_l  = sum_l * mix_t'(gain_l);
  assign mix_r  = sum_r * mix_t'(gain_r);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_l <= '0;
      out_r <= '0;
    end else if (!sound_on) begin
      out_l <= '0;
      out_r <= '0;
    end else begin
      out_l <= mix_l;
      out_r <= mix_r;
    end
  end

endmodule

`default_nettype wire

// File: src/apu_pulse_chan.sv
`timescale 1ns/1ps
`default_nettype none

module apu_pulse_chan (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       trigger,
  input  logic                       len_wr,
  input  logic [5:0]                 len_field,
  input  logic                       len_en,
  input  logic                       env_wr,
  input  apu_chan_pkg::vol_t         env_init,
  input  logic                       env_dir,
  input  apu_chan_pkg::env_period_t  env_period,
  input  apu_chan_pkg::freq_t        freq,
  input  apu_chan_pkg::duty_t        duty,
  input  logic                       length_tick,
  input  logic                       env_tick,
  output logic                       enabled,
  output apu_chan_pkg::vol_t         sample
);

  // Length field covers the bits the readback masks
  localparam logic [5:0] LEN_FIELD_MAX = apu_reg_pkg::MASK_LEN_DUTY[5:0];

  apu_chan_pkg::len_t         length;
  apu_chan_pkg::len_t         length_dec;
  apu_chan_pkg::len_t         length_load;
  apu_chan_pkg::vol_t         volume;
  apu_chan_pkg::env_period_t  env_cnt;
  apu_chan_pkg::freq_t        phase_timer;
  apu_chan_pkg::freq_t        timer_reload;
  logic [2:0]                 phase;
  logic                       duty_high;

  // ----------------------------------------
  // Length counter

  assign length_load = (len_field == '0) ? apu_chan_pkg::len_t'(64) :
                                           apu_chan_pkg::len_t'(LEN_FIELD_MAX ^ len_field);
  assign length_dec  = (len_en && length != '0) ? length - 1'b1 : length;

  always_ff @(posedge clk) begin
    if (rst) begin
      length <= '0;
    end else if (len_wr) begin
      length <= length_load;
    end else if (length_tick) begin
      length <= length_dec;
    end
  end

  // Trigger beats the DAC check, which beats expiry
  always_ff @(posedge clk) begin
    if (rst) begin
      enabled <= 1'b0;
    end else if (trigger) begin
      enabled <= 1'b1;
    end else if (env_wr) begin
      enabled <= |{env_init, env_dir, env_period};
    end else if (length_tick && length_dec == '0) begin
      enabled <= 1'b0;
    end
  end

  // ----------------------------------------
  // Volume envelope

  always_ff @(posedge clk) begin
    if (rst) begin
      volume  <= '0;
      env_cnt <= '0;
    end else if (trigger) begin
      volume  <= env_init;
      env_cnt <= env_period;
    end else if (env_tick && env_period != '0) begin
      if (env_cnt != '0) begin
        env_cnt <= env_cnt - 1'b1;
      end else begin
        env_cnt <= env_period;
        if (env_dir && volume != 4'hF) begin
          volume <= volume + 1'b1;
        end else if (!env_dir && volume != '0) begin
          volume <= volume - 1'b1;
        end
      end
    end
  end

  // ----------------------------------------
  // Phase timer

  // Same as 2047 xor freq
  assign timer_reload = ~freq;

  always_ff @(posedge clk) begin
    if (rst) begin
      phase_timer <= '0;
      phase       <= '0;
    end else if (trigger) begin
      phase_timer <= timer_reload;
      phase       <= '0;
    end else if (phase_timer == '0) begin
      phase_timer <= timer_reload;
      phase       <= phase + 1'b1;
    end else begin
      phase_timer <= phase_timer - 1'b1;
    end
  end

  // Duty output
  assign duty_high = phase < apu_chan_pkg::duty_steps(duty);

  always_ff @(posedge clk) begin
    if (rst) begin
      sample <= '0;
    end else begin
      sample <= (enabled && duty_high) ? volume : '0;
    end
  end

endmodule

`default_nettype wire

// File: src/apu_reg_pkg.sv
`default_nettype none

package apu_reg_pkg;

  // Bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] byte_t;

  // ----------------------------------------
  // Register map

  // Channel blocks are len/duty, envelope, freq lo, freq hi, then a gap
  localparam addr_t CHAN_BASE   = 16'hFF11;
  localparam int    CHAN_STRIDE = 5;

  localparam addr_t ADDR_MASTER_VOL = 16'hFF24;
  localparam addr_t ADDR_PAN        = 16'hFF25;
  localparam addr_t ADDR_POWER      = 16'hFF26;

  // ----------------------------------------
  // Read masks, ORed into the stored byte

  localparam byte_t MASK_LEN_DUTY   = 8'h3F;
  localparam byte_t MASK_ENV        = 8'h00;
  localparam byte_t MASK_FREQ_LO    = 8'hFF;
  localparam byte_t MASK_FREQ_HI    = 8'hBF;
  localparam byte_t MASK_POWER_FILL = 8'h70;

  // Channel entries first, in block offset order
  typedef enum logic [2:0] {
    REG_LEN_DUTY,
    REG_ENV,
    REG_FREQ_LO,
    REG_FREQ_HI,
    REG_MASTER_VOL,
    REG_PAN,
    REG_POWER,
    REG_NONE
  } reg_sel_e;

endpackage

`default_nettype wire

// File: src/apu_top.sv
`timescale 1ns/1ps
`default_nettype none

module apu_top #(
  parameter int N_CHAN = 2
) (
  input  logic                             clk,
  input  logic                             rst,
  input  apu_reg_pkg::addr_t               addr,
  input  apu_reg_pkg::byte_t               data,
  input  logic                             read,
  input  logic                             write,
  output apu_reg_pkg::byte_t               bus_out,
  output logic                             bus_oe,
  output logic [apu_chan_pkg::OUT_W-1:0]   out_l,
  output logic [apu_chan_pkg::OUT_W-1:0]   out_r
);

  logic [N_CHAN-1:0]                       trigger;
  logic [N_CHAN-1:0]                       len_wr;
  logic [N_CHAN-1:0][5:0]                  len_field;
  logic [N_CHAN-1:0]                       len_en;
  logic [N_CHAN-1:0]                       env_wr;
  apu_chan_pkg::vol_t [N_CHAN-1:0]         env_init;
  logic [N_CHAN-1:0]                       env_dir;
  apu_chan_pkg::env_period_t [N_CHAN-1:0]  env_period;
  apu_chan_pkg::freq_t [N_CHAN-1:0]        freq;
  apu_chan_pkg::duty_t [N_CHAN-1:0]        duty;
  logic [N_CHAN-1:0]                       enabled;
  apu_chan_pkg::vol_t [N_CHAN-1:0]         sample;
  logic                                    length_tick;
  logic                                    env_tick;
  logic                                    sound_on;
  apu_reg_pkg::byte_t                      pan;
  logic [2:0]                              master_l;
  logic [2:0]                              master_r;

  apu_ctrl #(
    .N_CHAN (N_CHAN)
  ) i_apu_ctrl (
    .clk         (clk),
    .rst         (rst),
    .addr        (addr),
    .data        (data),
    .read        (read),
    .write       (write),
    .enabled     (enabled),
    .bus_out     (bus_out),
    .bus_oe      (bus_oe),
    .trigger     (trigger),
    .len_wr      (len_wr),
    .len_field   (len_field),
    .len_en      (len_en),
    .env_wr      (env_wr),
    .env_init    (env_init),
    .env_dir     (env_dir),
    .env_period  (env_period),
    .freq        (freq),
    .duty        (duty),
    .length_tick (length_tick),
    .env_tick    (env_tick),
    .sound_on    (sound_on),
    .pan         (pan),
    .master_l    (master_l),
    .master_r    (master_r)
  );

  // ----------------------------------------
  // Pulse channels

  for (genvar c = 0; c < N_CHAN; c++) begin : g_chan
    apu_pulse_chan i_pulse (
      .clk         (clk),
      .rst         (rst),
      .trigger     (trigger[c]),
      .len_wr      (len_wr[c]),
      .len_field   (len_field[c]),
      .len_en      (len_en[c]),
      .env_wr      (env_wr[c]),
      .env_init    (env_init[c]),
      .env_dir     (env_dir[c]),
      .env_period  (env_period[c]),
      .freq        (freq[c]),
      .duty        (duty[c]),
      .length_tick (length_tick),
      .env_tick    (env_tick),
      .enabled     (enabled[c]),
      .sample      (sample[c])
    );
  end

  apu_mixer #(
    .N_CHAN (N_CHAN)
  ) i_apu_mixer (
    .clk      (clk),
    .rst      (rst),
    .sample   (sample),
    .sound_on (sound_on),
    .pan      (pan),
    .master_l (master_l),
    .master_r (master_r),
    .out_l    (out_l),
    .out_r    (out_r)
  );

endmodule

`default_nettype wire

// File: verif/apu_sva.sv
`timescale 1ns/1ps
`default_nettype none

module apu_sva #(
  parameter int N_CHAN = 2
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              read,
  input  logic                              bus_oe,
  input  logic                              sound_on,
  input  logic [N_CHAN-1:0]                 enabled,
  input  logic [apu_chan_pkg::OUT_W-1:0]    out_l,
  input  logic [apu_chan_pkg::OUT_W-1:0]    out_r
);

  int unsigned fail_count = 0;

  // Output enable only answers a read strobe
  a_oe_after_read : assert property (@(posedge clk) disable iff (rst) bus_oe |-> $past(read))
    else begin
      $error("bus_oe high without a read strobe one cycle before");
      fail_count++;
    end

  // Power off drains both outputs
  a_silent_when_off : assert property (@(posedge clk) disable iff (rst)
    (!sound_on ##1 !sound_on) |=> (out_l == '0 && out_r == '0))
    else begin
      $error("outputs not zero while sound is off");
      fail_count++;
    end

  a_status_after_reset : assert property (@(posedge clk)
    $fell(rst) |-> (enabled == '0 && !sound_on && !bus_oe))
    else begin
      $error("status bits not clear right after reset");
      fail_count++;
    end

endmodule

bind apu_top apu_sva #(
  .N_CHAN (N_CHAN)
) i_apu_sva (
  .clk      (clk),
  .rst      (rst),
  .read     (read),
  .bus_oe   (bus_oe),
  .sound_on (sound_on),
  .enabled  (enabled),
  .out_l    (out_l),
  .out_r    (out_r)
);

`default_nettype wire

// File: verif/apu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module apu_tb;

  localparam int N_CHAN = 2;
  // Envelope test runs about 49200 cycles, length test about 4200
  localparam int MAX_CYCLES = 120000;
  localparam int ENV_GAP    = 48960;
  localparam int OFS_LEN    = 0;
  localparam int OFS_ENV    = 1;
  localparam int OFS_LO     = 2;
  localparam int OFS_HI     = 3;
  localparam int STEPS [4]  = '{1, 2, 4, 6};
  localparam int MASKS [4]  = '{8'h3F, 8'h00, 8'hFF, 8'hBF};

  logic                                clk;
  logic                                rst;
  apu_reg_pkg::addr_t                  addr;
  apu_reg_pkg::byte_t                  data;
  logic                                read;
  logic                                write;
  apu_reg_pkg::byte_t                  bus_out;
  logic                                bus_oe;
  logic [apu_chan_pkg::OUT_W-1:0]      out_l;
  logic [apu_chan_pkg::OUT_W-1:0]      out_r;

  int          error_count  = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;
  int          cycle_count  = 0;
  logic [15:0] lfsr_state   = 16'd35319;

  apu_top #(
    .N_CHAN (N_CHAN)
  ) i_apu_top (
    .clk     (clk),
    .rst     (rst),
    .addr    (addr),
    .data    (data),
    .read    (read),
    .write   (write),
    .bus_out (bus_out),
    .bus_oe  (bus_oe),
    .out_l   (out_l),
    .out_r   (out_r)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin : watchdog
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run stopped after %0d cycles", cycle_count);
    $display("ERRORS FOUND");
    $finish;
  end

  // ----------------------------------------
  // Helpers

  // Galois LFSR, one step per bit
  function automatic int lfsr_bits(input int n);
    int   v;
    logic b;
    v = 0;
    for (int i = 0; i < n; i++) begin
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) lfsr_state = lfsr_state ^ 16'hB400;
      v = (v << 1) | int'(b);
    end
    return v;
  endfunction

  function automatic apu_reg_pkg::addr_t reg_addr(input int c, input int k);
    return apu_reg_pkg::addr_t'(apu_reg_pkg::CHAN_BASE + c * apu_reg_pkg::CHAN_STRIDE + k);
  endfunction

  task automatic report_mismatch(input string what, input int got, input int exp);
    $display("[FAIL] %0t ns: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
    error_count++;
  endtask

  task automatic close_test(input string name, input int errs_at_start);
    tests_run++;
    if (error_count == errs_at_start) begin
      $display("Test %s: passed", name);
    end else begin
      $display("Test %s: failed", name);
      tests_failed++;
    end
  endtask

  // All bus tasks start and end 1 ns after a rising edge
  task automatic bus_write(input apu_reg_pkg::addr_t a, input int d);
    addr  = a;
    data  = apu_reg_pkg::byte_t'(d);
    write = 1'b1;
    @(posedge clk);
    #1;
    write = 1'b0;
  endtask

  task automatic bus_read(input apu_reg_pkg::addr_t a, output int d, output logic oe);
    addr = a;
    read = 1'b1;
    @(posedge clk);
    #1;
    read = 1'b0;
    d    = int'(bus_out);
    oe   = bus_oe;
  endtask

  // Read a mapped register and compare the byte
  task automatic check_read(input apu_reg_pkg::addr_t a, input int exp, input string what);
    int   d;
    logic oe;
    bus_read(a, d, oe);
    if (!oe) begin
      $display("[FAIL] %0t ns: %s: bus_oe stayed low for a mapped register", $time, what);
      error_count++;
    end else if (d != exp) begin
      report_mismatch(what, d, exp);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic measure_peak(input int n, output int pk_l, output int pk_r);
    pk_l = 0;
    pk_r = 0;
    repeat (n) begin
      @(posedge clk);
      #1;
      if (int'(out_l) > pk_l) pk_l = int'(out_l);
      if (int'(out_r) > pk_r) pk_r = int'(out_r);
    end
  endtask

  // ----------------------------------------
  // Directed tests

  task automatic readback_test();
    int   e0;
    int   d;
    logic oe;
    e0 = error_count;
    for (int c = 0; c < N_CHAN; c++) begin
      bus_write(reg_addr(c, OFS_LEN), 8'h4C + c);
      bus_write(reg_addr(c, OFS_ENV), 8'hA3 + 8'h11 * c);
      bus_write(reg_addr(c, OFS_LO), 8'h3C + 8'h05 * c);
      bus_write(reg_addr(c, OFS_HI), 8'h45 + c);
    end
    bus_write(apu_reg_pkg::ADDR_MASTER_VOL, 8'h52);
    bus_write(apu_reg_pkg::ADDR_PAN, 8'hC9);
    bus_write(apu_reg_pkg::ADDR_POWER, 8'h80);
    for (int c = 0; c < N_CHAN; c++) begin
      check_read(reg_addr(c, OFS_LEN), (8'h4C + c) | MASKS[0], "len/duty read");
      check_read(reg_addr(c, OFS_ENV), (8'hA3 + 8'h11 * c) | MASKS[1], "envelope read");
      check_read(reg_addr(c, OFS_LO), (8'h3C + 8'h05 * c) | MASKS[2], "freq lo read");
      check_read(reg_addr(c, OFS_HI), (8'h45 + c) | MASKS[3], "freq hi read");
    end
    check_read(apu_reg_pkg::ADDR_MASTER_VOL, 8'h52, "master volume read");
    check_read(apu_reg_pkg::ADDR_PAN, 8'hC9, "pan read");
    // Nonzero envelope bytes turned both DACs on
    check_read(apu_reg_pkg::ADDR_POWER, 8'h80 | 8'h70 | 8'h03, "power read");
    bus_read(16'hFF10, d, oe);
    if (oe) report_mismatch("bus_oe at FF10", int'(oe), 0);
    bus_read(16'hFF15, d, oe);
    if (oe) report_mismatch("bus_oe at FF15", int'(oe), 0);
    close_test("readback", e0);
  endtask

  task automatic duty_test();
    int e0;
    int v;
    int count;
    e0 = error_count;
    v  = lfsr_bits(4);
    if (v == 0) v = 1;
    bus_write(reg_addr(1, OFS_ENV), 8'h00);
    bus_write(apu_reg_pkg::ADDR_POWER, 8'h80);
    bus_write(apu_reg_pkg::ADDR_MASTER_VOL, 8'h33);
    bus_write(apu_reg_pkg::ADDR_PAN, 8'h01);
    bus_write(reg_addr(0, OFS_ENV), v << 4);
    bus_write(reg_addr(0, OFS_LEN), 8'h00);
    bus_write(reg_addr(0, OFS_LO), 8'hFF);
    bus_write(reg_addr(0, OFS_HI), 8'h87);
    for (int d = 0; d < 4; d++) begin
      bus_write(reg_addr(0, OFS_LEN), d << 6);
      idle(4);
      count = 0;
      repeat (64) begin
        @(posedge clk);
        #1;
        if (out_r != '0) begin
          count++;
          if (int'(out_r) != v * 4) report_mismatch("out_r level", int'(out_r), v * 4);
        end
        if (out_l != '0) report_mismatch("out_l level", int'(out_l), 0);
      end
      if (count != 8 * STEPS[d]) report_mismatch("high sample count", count, 8 * STEPS[d]);
    end
    close_test("duty", e0);
  endtask

  task automatic mix_test();
    int e0;
    int vol [2];
    int pan;
    int ml;
    int mr;
    int exp_l;
    int exp_r;
    int pk_l;
    int pk_r;
    e0     = error_count;
    vol[0] = lfsr_bits(4);
    vol[1] = lfsr_bits(4);
    pan    = lfsr_bits(8);
    ml     = lfsr_bits(3);
    mr     = lfsr_bits(3);
    bus_write(apu_reg_pkg::ADDR_MASTER_VOL, (ml << 4) | mr);
    bus_write(apu_reg_pkg::ADDR_PAN, pan);
    for (int c = 0; c < N_CHAN; c++) begin
      bus_write(reg_addr(c, OFS_ENV), vol[c] << 4);
      bus_write(reg_addr(c, OFS_LEN), 8'hC0);
      bus_write(reg_addr(c, OFS_LO), 8'hFF);
    end
    // One cycle apart, so the 6/8 high windows overlap
    bus_write(reg_addr(0, OFS_HI), 8'h87);
    bus_write(reg_addr(1, OFS_HI), 8'h87);
    exp_r = ((pan[0] ? vol[0] : 0) + (pan[1] ? vol[1] : 0)) * (mr + 1);
    exp_l = ((pan[4] ? vol[0] : 0) + (pan[5] ? vol[1] : 0)) * (ml + 1);
    idle(2);
    measure_peak(64, pk_l, pk_r);
    if (pk_r != exp_r) report_mismatch("peak out_r", pk_r, exp_r);
    if (pk_l != exp_l) report_mismatch("peak out_l", pk_l, exp_l);
    bus_write(apu_reg_pkg::ADDR_POWER, 8'h00);
    idle(2);
    measure_peak(16, pk_l, pk_r);
    if (pk_l != 0 || pk_r != 0) report_mismatch("output with power off", pk_l | pk_r, 0);
    close_test("mixing", e0);
  endtask

  task automatic length_test();
    int e0;
    e0 = error_count;
    bus_write(apu_reg_pkg::ADDR_POWER, 8'h80);
    bus_write(reg_addr(1, OFS_ENV), 8'h00);
    bus_write(reg_addr(0, OFS_ENV), 8'hF0);
    bus_write(reg_addr(0, OFS_LEN), 8'h80 | 62);
    bus_write(reg_addr(0, OFS_HI), 8'hC7);
    check_read(apu_reg_pkg::ADDR_POWER, 8'hF1, "status after trigger");
    idle(4100);
    check_read(apu_reg_pkg::ADDR_POWER, 8'hF0, "status after length expiry");
    close_test("length", e0);
  endtask

  task automatic envelope_test();
    int e0;
    int pk_l;
    int pk_r;
    e0 = error_count;
    bus_write(apu_reg_pkg::ADDR_MASTER_VOL, 8'h33);
    bus_write(apu_reg_pkg::ADDR_PAN, 8'h01);
    bus_write(reg_addr(0, OFS_ENV), 8'h59);
    bus_write(reg_addr(0, OFS_LEN), 8'hC0);
    bus_write(reg_addr(0, OFS_LO), 8'hFF);
    bus_write(reg_addr(0, OFS_HI), 8'h87);
    idle(2);
    measure_peak(64, pk_l, pk_r);
    if (pk_r != 5 * 4) report_mismatch("peak before envelope step", pk_r, 5 * 4);
    // Both windows stay inside 3 * 16384 cycles of the trigger
    idle(ENV_GAP);
    measure_peak(64, pk_l, pk_r);
    if (pk_r != 6 * 4) report_mismatch("peak after envelope step", pk_r, 6 * 4);
    close_test("envelope", e0);
  endtask

  task automatic dac_off_test();
    int e0;
    e0 = error_count;
    for (int c = 0; c < N_CHAN; c++) begin
      bus_write(reg_addr(c, OFS_ENV), 8'hA0);
      bus_write(reg_addr(c, OFS_LEN), 8'h00);
      bus_write(reg_addr(c, OFS_HI), 8'h87);
      check_read(apu_reg_pkg::ADDR_POWER, 8'hF0 | (1 << c), "status before DAC off");
      bus_write(reg_addr(c, OFS_ENV), 8'h00);
      check_read(apu_reg_pkg::ADDR_POWER, 8'hF0, "status after DAC off");
    end
    close_test("dac_off", e0);
  endtask

  // ----------------------------------------
  // Main sequence

  initial begin
    rst   = 1'b1;
    addr  = '0;
    data  = '0;
    read  = 1'b0;
    write = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    idle(2);
    readback_test();
    duty_test();
    mix_test();
    length_test();
    envelope_test();
    dac_off_test();
    $display("Tests run: %0d, failed: %0d, check errors: %0d, assertion failures: %0d",
             tests_run, tests_failed, error_count, i_apu_top.i_apu_sva.fail_count);
    if (error_count == 0 && i_apu_top.i_apu_sva.fail_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
